// File: include/engine_consts.svh
// Lane count and widths are fixed at build time and the op codes keep the host register encoding
`ifndef ENGINE_CONSTS_SVH
`define ENGINE_CONSTS_SVH

// Lane array geometry
`define ENGINE_LANES      16
`define ENGINE_DATA_W     16 // Operand and result word
`define ENGINE_ACC_W      32 // Holds a full 16x16 signed product

// Width of the op_num round count
`define ENGINE_ROUND_W    16

// Op codes seen on op_type
`define ENGINE_OP_W       3
`define ENGINE_OP_CONV    3'd1
`define ENGINE_OP_MAXPOOL 3'd4

`endif

// File: src/engine_pkg.sv
// Engine types sized from the consts header so every width is fixed for one build
`default_nettype none
`include "engine_consts.svh"

package engine_pkg;

	typedef logic signed [`ENGINE_DATA_W-1:0]  data_t;  // Operand or result word
	typedef logic signed [`ENGINE_ACC_W-1:0]   acc_t;   // Per-lane accumulator

	typedef logic [$clog2(`ENGINE_LANES)-1:0]  lane_t;
	typedef logic [`ENGINE_ROUND_W-1:0]        round_t; // Round count of a job

	// Operation carried by the start pulse
	typedef enum logic [`ENGINE_OP_W-1:0] {
		op_conv    = `ENGINE_OP_CONV,
		op_maxpool = `ENGINE_OP_MAXPOOL
	} op_e;

	// Operand fetch sequencing
	typedef enum logic [1:0] {
		idle,
		fetch,
		drain
	} fetch_state_e;

endpackage

`default_nettype wire

// File: src/operand_fetch.sv
// Assumes the operand FIFOs never run empty and takes start only in idle with a nonzero op_num
`timescale 1ns/10ps
`default_nettype none
`include "engine_consts.svh"

module operand_fetch (
	input  wire                       clk,
	input  wire                       rst,
	input  wire                       start,
	input  wire engine_pkg::op_e      op_type,
	input  wire engine_pkg::round_t   op_num,
	output logic                      data_rd_en,
	output logic                      weight_rd_en,
	output logic                      sample_valid,
	output engine_pkg::lane_t         sample_lane,
	output logic                      first_round,
	output logic                      last_sample,
	output engine_pkg::op_e           job_op
);

	localparam engine_pkg::lane_t last_lane = engine_pkg::lane_t'(`ENGINE_LANES - 1);

	engine_pkg::fetch_state_e state;
	engine_pkg::round_t       job_rounds; // Latched op_num
	engine_pkg::round_t       round_cnt;
	engine_pkg::lane_t        lane_cnt;   // Lane of the strobe in this cycle
	logic                     last_strobe;

	// Final lane of the final round
	assign last_strobe = (lane_cnt == last_lane) &&
		(round_cnt == job_rounds - engine_pkg::round_t'(1));

	always_ff @(posedge clk or posedge rst) begin
		if (rst) begin
			state        <= engine_pkg::idle;
			job_op       <= engine_pkg::op_conv;
			job_rounds   <= '0;
			round_cnt    <= '0;
			lane_cnt     <= '0;
			data_rd_en   <= 1'b0;
			weight_rd_en <= 1'b0;
		end else begin
			case (state)
				engine_pkg::idle: begin
					if (start && op_num != '0) begin
						state        <= engine_pkg::fetch;
						job_op       <= op_type;
						job_rounds   <= op_num;
						round_cnt    <= '0;
						lane_cnt     <= '0;
						data_rd_en   <= 1'b1;
						weight_rd_en <= (op_type == engine_pkg::op_conv); // No weights for max-pool
					end
				end
				engine_pkg::fetch: begin
					if (lane_cnt == last_lane) begin
						lane_cnt  <= '0;
						round_cnt <= round_cnt + engine_pkg::round_t'(1);
					end else begin
						lane_cnt <= lane_cnt + engine_pkg::lane_t'(1);
					end
					if (last_strobe) begin
						state        <= engine_pkg::drain;
						data_rd_en   <= 1'b0;
						weight_rd_en <= 1'b0;
					end
				end
				engine_pkg::drain: state <= engine_pkg::idle; // Last operand lands this cycle
				default: state <= engine_pkg::idle;
			endcase
		end
	end

	// Tags line up with the operand the FIFO presents one cycle after its strobe
	always_ff @(posedge clk or posedge rst) begin
		if (rst) begin
			sample_valid <= 1'b0;
			sample_lane  <= '0;
			first_round  <= 1'b0;
			last_sample  <= 1'b0;
		end else begin
			sample_valid <= data_rd_en;
			sample_lane  <= lane_cnt;
			first_round  <= (round_cnt == '0);
			last_sample  <= data_rd_en && last_strobe;
		end
	end

	// Weight reads only ever ride along with data reads of a convolution
	assert property (@(posedge clk) disable iff (rst)
		weight_rd_en |-> (data_rd_en && job_op == engine_pkg::op_conv));

endmodule

`default_nettype wire

// File: src/lane_array.sv
// One operand per cycle at most and lane results are the low ENGINE_DATA_W bits of each accumulator
`timescale 1ns/10ps
`default_nettype none
`include "engine_consts.svh"

module lane_array (
	input  wire                                    clk,
	input  wire                                    rst,
	input  wire engine_pkg::data_t                 data,
	input  wire engine_pkg::data_t                 weight,
	input  wire                                    sample_valid,
	input  wire engine_pkg::lane_t                 sample_lane,
	input  wire                                    first_round,
	input  wire                                    last_sample,
	input  wire engine_pkg::op_e                   job_op,
	output logic                                   results_ready,
	output engine_pkg::data_t [`ENGINE_LANES-1:0]  lane_results
);

	engine_pkg::acc_t acc [`ENGINE_LANES];
	engine_pkg::acc_t cur;       // Accumulator of the tagged lane
	engine_pkg::acc_t sample;    // Data sign-extended
	engine_pkg::acc_t product;
	engine_pkg::acc_t lane_next;

	assign cur     = acc[sample_lane];
	assign sample  = engine_pkg::acc_t'(data);
	assign product = engine_pkg::acc_t'(data) * engine_pkg::acc_t'(weight);

	always_comb begin
		if (job_op == engine_pkg::op_maxpool) begin
			// Signed max, first round seeds the lane
			lane_next = (first_round || sample > cur) ? sample : cur;
		end else begin
			lane_next = first_round ? product : cur + product;
		end
	end

	always_ff @(posedge clk) begin
		if (sample_valid) begin
			acc[sample_lane] <= lane_next;
		end
	end

	// Last lane was updated at the same edge
	always_ff @(posedge clk or posedge rst) begin
		if (rst) begin
			results_ready <= 1'b0;
		end else begin
			results_ready <= last_sample;
		end
	end

	always_comb begin
		for (int i = 0; i < `ENGINE_LANES; i++) begin
			lane_results[i] = acc[i][`ENGINE_DATA_W-1:0]; // Wraps on overflow
		end
	end

	// The fetch stage only tags lanes that exist
	assert property (@(posedge clk) disable iff (rst)
		sample_valid |-> (32'(sample_lane) < `ENGINE_LANES));

endmodule

`default_nettype wire

// File: src/result_writeback.sv
// Assumes the result FIFO is never full and a new result set never arrives mid-writeback
`timescale 1ns/10ps
`default_nettype none
`include "engine_consts.svh"

module result_writeback (
	input  wire                                        clk,
	input  wire                                        rst,
	input  wire                                        results_ready,
	input  wire engine_pkg::data_t [`ENGINE_LANES-1:0] lane_results,
	output engine_pkg::data_t                          result,
	output logic                                       result_wr_en,
	output logic                                       done
);

	localparam engine_pkg::lane_t last_lane = engine_pkg::lane_t'(`ENGINE_LANES - 1);

	engine_pkg::data_t [`ENGINE_LANES-1:0] capture_buf; // Frees the lanes for the next job
	engine_pkg::lane_t                     wb_lane;
	logic                                  active;

	always_ff @(posedge clk) begin
		if (results_ready) begin
			capture_buf <= lane_results;
		end
	end

	always_ff @(posedge clk or posedge rst) begin
		if (rst) begin
			active  <= 1'b0;
			wb_lane <= '0;
			done    <= 1'b0;
		end else begin
			done <= active && (wb_lane == last_lane); // Cycle after the last write
			if (results_ready) begin
				active  <= 1'b1;
				wb_lane <= '0;
			end else if (active) begin
				if (wb_lane == last_lane) begin
					active  <= 1'b0;
					wb_lane <= '0;
				end else begin
					wb_lane <= wb_lane + engine_pkg::lane_t'(1);
				end
			end
		end
	end

	assign result       = capture_buf[wb_lane];
	assign result_wr_en = active;

	// Fetch and lane timing must leave room for a full writeback
	assert property (@(posedge clk) disable iff (rst)
		results_ready |-> !active);

endmodule

`default_nettype wire

// File: src/engine_top.sv
// No handshakes on any port so operand FIFOs must stay non-empty and the result FIFO non-full
`timescale 1ns/10ps
`default_nettype none
`include "engine_consts.svh"

module engine_top (
	input  wire                       clk,
	input  wire                       rst,
	input  wire                       start,
	input  wire engine_pkg::op_e      op_type,
	input  wire engine_pkg::round_t   op_num,
	input  wire engine_pkg::data_t    data,
	input  wire engine_pkg::data_t    weight,
	output wire                       data_rd_en,
	output wire                       weight_rd_en,
	output engine_pkg::data_t         result,
	output wire                       result_wr_en,
	output wire                       done
);

	// Fetch to lanes
	wire                                   sample_valid;
	engine_pkg::lane_t                     sample_lane;
	wire                                   first_round;
	wire                                   last_sample;
	engine_pkg::op_e                       job_op;

	// Lanes to writeback
	wire                                   results_ready;
	engine_pkg::data_t [`ENGINE_LANES-1:0] lane_results;

	operand_fetch u_fetch (
		.clk          (clk),
		.rst          (rst),
		.start        (start),
		.op_type      (op_type),
		.op_num       (op_num),
		.data_rd_en   (data_rd_en),
		.weight_rd_en (weight_rd_en),
		.sample_valid (sample_valid),
		.sample_lane  (sample_lane),
		.first_round  (first_round),
		.last_sample  (last_sample),
		.job_op       (job_op)
	);

	lane_array u_lanes (
		.clk           (clk),
		.rst           (rst),
		.data          (data),
		.weight        (weight),
		.sample_valid  (sample_valid),
		.sample_lane   (sample_lane),
		.first_round   (first_round),
		.last_sample   (last_sample),
		.job_op        (job_op),
		.results_ready (results_ready),
		.lane_results  (lane_results)
	);

	result_writeback u_wb (
		.clk           (clk),
		.rst           (rst),
		.results_ready (results_ready),
		.lane_results  (lane_results),
		.result        (result),
		.result_wr_en  (result_wr_en),
		.done          (done)
	);

endmodule

`default_nettype wire

// File: tb/engine_tb.sv
// Runs from the project root to find tb/engine_stim.txt and models FIFOs that never stall
`timescale 1ns/10ps
`default_nettype none
`include "engine_consts.svh"

module engine_tb;

	localparam int lanes     = `ENGINE_LANES;
	localparam int stim_size = 512;

	logic               clk;
	logic               rst;
	logic               start;
	engine_pkg::op_e    op_type;
	engine_pkg::round_t op_num;
	engine_pkg::data_t  data;
	engine_pkg::data_t  weight;
	wire                data_rd_en;
	wire                weight_rd_en;
	engine_pkg::data_t  result;
	wire                result_wr_en;
	wire                done;

	logic [15:0] stim_mem [stim_size];
	logic [15:0] data_q[$];     // Operands not yet presented
	logic [15:0] weight_q[$];
	logic [15:0] exp_q[$];      // Results not yet written
	logic [15:0] exp_word;
	logic [15:0] next_weight;
	integer      seed         = 96646;
	integer      rnd;
	int          wr_cnt       = 0; // Writes since the last done
	int          done_cnt     = 0;
	int          jobs_run     = 0;
	int          limit_cycles = 0;
	logic        rd_pending   = 1'b0; // Strobe taken at the coming rising edge
	logic        wr_pending   = 1'b0;

	engine_top dut (
		.clk          (clk),
		.rst          (rst),
		.start        (start),
		.op_type      (op_type),
		.op_num       (op_num),
		.data         (data),
		.weight       (weight),
		.data_rd_en   (data_rd_en),
		.weight_rd_en (weight_rd_en),
		.result       (result),
		.result_wr_en (result_wr_en),
		.done         (done)
	);

	initial begin
		clk = 1'b0;
		forever #4 clk = ~clk;
	end

	task automatic stop_on_error(input string msg);
		$display("%s", msg);
		$display("Checks failed");
		$fatal(1, "Simulation stopped at the first error");
	endtask

	task automatic check_idle(input string when_txt);
		assert (!data_rd_en && !weight_rd_en && !result_wr_en && !done)
			else stop_on_error($sformatf("CHECK FAILED at %0t: outputs active %s", $time, when_txt));
	endtask

	// Operand FIFOs, one pair in the cycle after each read strobe
	always @(negedge clk) begin
		if (rd_pending) begin
			assert (data_q.size() > 0) else stop_on_error("Read strobe with no operand left to give");
			rnd         = $random(seed);
			next_weight = weight_q.pop_front();
			data        = data_q.pop_front();
			weight      = wr_pending ? next_weight : rnd[15:0]; // Garbage when weights are unread
		end
		rd_pending = data_rd_en;
		wr_pending = weight_rd_en;
	end

	// Result FIFO side
	always @(negedge clk) begin
		if (result_wr_en) begin
			assert (exp_q.size() > 0) else stop_on_error("Result written with none expected");
			exp_word = exp_q.pop_front();
			assert (result === exp_word)
				else stop_on_error($sformatf("CHECK FAILED at %0t: write %0d gave %h, expected %h",
					$time, wr_cnt, result, exp_word));
			wr_cnt++;
		end
		if (done) begin
			assert (wr_cnt == lanes && !result_wr_en)
				else stop_on_error($sformatf("CHECK FAILED at %0t: done after %0d writes",
					$time, wr_cnt));
			wr_cnt = 0;
			done_cnt++;
		end
	end

	initial begin
		wait (limit_cycles > 0);
		repeat (limit_cycles) @(posedge clk);
		$display("Timeout: the jobs did not finish within %0d cycles", limit_cycles);
		$display("Checks failed");
		$fatal(1, "Watchdog expired");
	end

	initial begin
		int              idx;
		int              jobs;
		int              num;
		int              mode;
		int              rd_cnt;
		int              total;
		engine_pkg::op_e op;
		start   = 1'b0;
		op_type = engine_pkg::op_conv;
		op_num  = '0;
		data    = '0;
		weight  = '0;
		rst     = 1'b1;
		$readmemh("tb/engine_stim.txt", stim_mem);
		jobs  = int'(stim_mem[0]);
		idx   = 1;
		total = 40; // Reset and idle window
		for (int j = 0; j < jobs; j++) begin
			num   = int'(stim_mem[idx + 1]);
			total += (num + 1) * lanes + 20;
			idx   += 3 + ((num > 0) ? num * 2 * lanes + lanes : 0);
		end
		limit_cycles = total;
		repeat (5) @(posedge clk);
		@(negedge clk);
		rst = 1'b0;
		repeat (5) begin
			@(negedge clk);
			check_idle("before the first start");
		end
		idx = 1;
		for (int j = 0; j < jobs; j++) begin
			op   = engine_pkg::op_e'(stim_mem[idx][`ENGINE_OP_W-1:0]);
			num  = int'(stim_mem[idx + 1]);
			mode = int'(stim_mem[idx + 2]);
			idx += 3;
			for (int k = 0; k < num * lanes; k++) begin
				data_q.push_back(stim_mem[idx]);
				weight_q.push_back(stim_mem[idx + 1]);
				idx += 2;
			end
			if (num > 0) begin
				for (int k = 0; k < lanes; k++) begin
					exp_q.push_back(stim_mem[idx + k]);
				end
				idx += lanes;
			end
			if (mode == 2) begin
				@(negedge clk); // Drain cycle of the previous fetch
			end else begin
				wait (done_cnt == jobs_run);
				@(negedge clk);
			end
			start   = 1'b1;
			op_type = op;
			op_num  = engine_pkg::round_t'(num);
			@(negedge clk);
			start = 1'b0;
			if (num == 0) begin
				repeat (20) begin
					check_idle("after a start with op_num of zero");
					@(negedge clk);
				end
			end else begin
				jobs_run++;
				rd_cnt = 0;
				while (rd_cnt == 0 || data_rd_en) begin
					if (data_rd_en) begin
						rd_cnt++;
						assert (weight_rd_en == (op == engine_pkg::op_conv))
							else stop_on_error($sformatf("CHECK FAILED at %0t: weight_rd_en is %b",
								$time, weight_rd_en));
					end
					if (mode == 1 && rd_cnt == lanes + 3) begin
						start   = 1'b1; // Must be ignored mid-fetch
						op_type = engine_pkg::op_maxpool;
						op_num  = engine_pkg::round_t'(1);
					end else begin
						start = 1'b0;
					end
					@(negedge clk);
				end
				assert (rd_cnt == num * lanes && !weight_rd_en)
					else stop_on_error($sformatf("CHECK FAILED at %0t: %0d read strobes, expected %0d",
						$time, rd_cnt, num * lanes));
			end
		end
		wait (done_cnt == jobs_run);
		@(negedge clk);
		assert (exp_q.size() == 0 && data_q.size() == 0)
			else stop_on_error("Results or operands were left over after the last job");
		$display("All checks passed");
		$finish;
	end

endmodule

`default_nettype wire

// File: engine.f
+incdir+include
src/engine_pkg.sv
src/operand_fetch.sv
src/lane_array.sv
src/result_writeback.sv
src/engine_top.sv
tb/engine_tb.sv

// File: Makefile
# Verilator build and run of the burst compute engine testbench
VERILATOR ?= verilator
TOP       ?= engine_tb
FILELIST  ?= engine.f
BUILD_DIR ?= obj_dir
VFLAGS    ?= --binary --timing --assert -j 0
PASS_MSG  ?= All checks passed

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build the testbench with Verilator and run it"
	@echo "  clean  remove the build directory"
	@echo "  help   show this list"
	@echo "Variables: VERILATOR TOP FILELIST BUILD_DIR VFLAGS"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)
	@out="$$($(BUILD_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -q "$(PASS_MSG)"

clean:
	rm -rf $(BUILD_DIR)

// File: tb/engine_stim.txt
// First word is the job count. Job line is op code, op_num, mode (0 after done, 1 stray start, 2 back-to-back)
// Then op_num rounds of 16 data/weight pairs over two lines, then 16 expected results if op_num > 0
0003
0001 0000 0000
0001 0002 0001
0001 0002 0005 0006 ffff 0003 0010 0010 fffe fffd 0064 ff9c 0000 7fff 7fff 0002
0100 0100 8000 ffff 0003 0003 0020 ffe0 0800 0010 00ff 00ff fff6 0007 1234 0001
0003 0004 0007 0008 0002 0002 0001 0001 0000 1234 000a 000a 0000 8000 0001 0001
0000 0000 0000 0000 0003 0003 0001 0005 0001 0001 0002 ffff fffb fffb 0001 1234
000e 0056 0001 0101 0006 d954 0000 ffff 0000 8000 0012 fc05 8001 fdff ffd3 2468
0004 0003 0002
0001 0000 0003 0000 ffff 0000 fffd 0000 8000 0000 7fff 0000 0000 0000 ff00 0000
1234 0000 8000 0000 fff0 0000 0100 0000 c000 0000 0005 0000 00aa 0000 ffe0 0000
0002 0000 0002 0000 fffe 0000 fffe 0000 8001 0000 8000 0000 ffff 0000 00ff 0000
1233 0000 8000 0000 0000 0000 7ffe 0000 a000 0000 fffb 0000 0055 0000 ffc0 0000
0003 0000 0001 0000 fffd 0000 ffff 0000 8000 0000 0000 0000 0001 0000 0010 0000
1235 0000 8000 0000 fff8 0000 7ffd 0000 b000 0000 0004 0000 00ab 0000 ffe1 0000
0003 0003 ffff ffff 8001 7fff 0001 00ff 1235 8000 0000 7ffe c000 0005 00ab ffe1
